// File: hdl/fetch_defines.svh
`ifndef FETCH_DEFINES_SVH
`define FETCH_DEFINES_SVH

// ***************************************************************************
// buffer geometry
// ***************************************************************************

`define FETCH_DEPTH 8                        // entries, power of two.
`define FETCH_INDEX_W ($clog2(`FETCH_DEPTH))

// prefetching stops at this many buffered halfwords.
`define FETCH_LIMIT (2 * `FETCH_DEPTH - 2)

// ***************************************************************************
// data path
// ***************************************************************************

`define XLEN 32                              // address and word width.
`define FETCH_TAG_W (`XLEN - 2)              // word address.

`endif

// File: hdl/mem_pkg.sv
`include "fetch_defines.svh"

package mem_pkg;

  // request from the fetch stage.
  typedef struct packed {
    logic valid;
    logic fence;                             // wipe the buffer.
    logic spec;                              // redirect the stream.
    logic [`XLEN-1:0] addr;
  } mem_req_t;

  // answer to the fetch stage.
  typedef struct packed {
    logic ready;
    logic error;
    logic [`XLEN-1:0] rdata;
  } mem_resp_t;

endpackage

// File: hdl/fetch_pkg.sv
`include "fetch_defines.svh"

package fetch_pkg;

  // one buffered word, 64 bits.
  typedef struct packed {
    logic error;                             // bus error on fetch.
    logic valid;
    logic [`FETCH_TAG_W-1:0] tag;            // word address.
    logic [`XLEN-1:0] data;
  } fetch_entry_t;

  typedef enum logic [1:0] {
    st_idle,
    st_active,                               // sequential prefetch.
    st_drain,                                // wait out the fetch in flight.
    st_clear                                 // fence sweep.
  } fetch_state_t;

endpackage

// File: hdl/fetch_ram_if.sv
`include "fetch_defines.svh"

interface fetch_ram_if #(
  parameter type entry_t = fetch_pkg::fetch_entry_t
);

  logic wen;
  logic [`FETCH_INDEX_W-1:0] waddr;
  entry_t wdata;
  logic [`FETCH_INDEX_W-1:0] raddr1;
  logic [`FETCH_INDEX_W-1:0] raddr2;
  entry_t rdata1;
  entry_t rdata2;

  modport writer (
    output wen, waddr, wdata
  );

  // wen and wdata feed the write bypass.
  modport reader (
    input wen, wdata, rdata1, rdata2,
    output raddr1, raddr2
  );

  modport store (
    input wen, waddr, wdata, raddr1, raddr2,
    output rdata1, rdata2
  );

endinterface

// File: hdl/fetch_ram.sv
`include "fetch_defines.svh"

module fetch_ram #(
  parameter type entry_t = fetch_pkg::fetch_entry_t,
  parameter int depth = `FETCH_DEPTH
) (
  input logic clock,
  fetch_ram_if.store ram
);

  entry_t mem [depth] = '{default: '0};

  always_ff @(posedge clock) begin
    if (ram.wen) begin
      mem[ram.waddr] <= ram.wdata;
    end
  end

  // two asynchronous read ports.
  assign ram.rdata1 = mem[ram.raddr1];
  assign ram.rdata2 = mem[ram.raddr2];

endmodule

// File: hdl/fetch_occupancy.sv
`include "fetch_defines.svh"

module fetch_occupancy (
  input logic clock,
  input logic reset,
  input logic refill,
  input logic clear,
  input logic [1:0] step,
  output logic full
);

  localparam int count_w = `FETCH_INDEX_W + 2;

  logic [count_w-1:0] count_q;
  logic [count_w-1:0] filled;
  logic [count_w-1:0] count_d;

  assign filled = refill ? count_q + count_w'(2) : count_q;   // one word in.

  always_comb begin
    count_d = filled;
    if (clear) begin
      count_d = '0;
    end else if (count_w'(step) <= filled) begin
      count_d = filled - count_w'(step);                      // halfwords out.
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      count_q <= '0;
    end else begin
      count_q <= count_d;
    end
  end

  assign full = (int'(count_q) >= `FETCH_LIMIT);

endmodule

// File: hdl/fetch_ctrl.sv
`include "fetch_defines.svh"

module fetch_ctrl (
  input logic clock,
  input logic reset,
  input mem_pkg::mem_req_t req,
  input logic imem_ready,
  input logic imem_error,
  input logic [31:0] imem_rdata,
  input logic full,
  output logic imem_valid,
  output logic [31:0] imem_addr,
  output logic refill,
  output logic clear,
  fetch_ram_if.writer ram
);

  import fetch_pkg::*;

  fetch_state_t state_q;
  fetch_state_t state_d;
  logic [31:0] addr_q;
  logic [31:0] spec_addr_q;
  logic [31:0] spec_addr;
  logic [`FETCH_INDEX_W-1:0] sweep_q;
  logic fence_q;
  logic spec_q;
  logic busy_q;
  logic fence_pend;
  logic spec_pend;
  logic drain_done;
  logic sweep_last;
  logic spec_take;

  assign fence_pend = fence_q | (req.valid & req.fence);
  assign spec_pend = spec_q | (req.valid & req.spec);
  assign spec_addr = (req.valid & req.spec) ? req.addr : spec_addr_q;
  assign drain_done = imem_ready | ~busy_q;       // nothing left in flight.
  assign sweep_last = (int'(sweep_q) == `FETCH_DEPTH - 1);
  assign spec_take = (state_q == st_drain) & drain_done & ~fence_pend;

  // ***************************************************************************
  // next state and entry writes
  // ***************************************************************************

  always_comb begin
    state_d = state_q;
    ram.wen = 1'b0;
    ram.waddr = addr_q[`FETCH_INDEX_W+1:2];
    ram.wdata = '0;
    refill = 1'b0;
    clear = 1'b0;
    case (state_q)
      st_idle: begin
        state_d = st_active;
      end
      st_active: begin
        if (imem_ready) begin
          ram.wen = 1'b1;
          ram.wdata.error = imem_error;
          ram.wdata.valid = 1'b1;
          ram.wdata.tag = addr_q[31:2];
          ram.wdata.data = imem_rdata;
          refill = 1'b1;
        end
        if (fence_pend | spec_pend) begin
          state_d = st_drain;
        end
      end
      st_drain: begin
        if (drain_done) begin
          state_d = fence_pend ? st_clear : st_active;
          clear = ~fence_pend;                    // redirect empties the count.
        end
      end
      st_clear: begin
        ram.wen = 1'b1;                           // zero entry.
        ram.waddr = sweep_q;
        if (sweep_last) begin
          state_d = st_active;
          clear = 1'b1;
        end
      end
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state_q <= st_idle;
      addr_q <= '0;
      sweep_q <= '0;
      fence_q <= 1'b0;
      spec_q <= 1'b0;
      busy_q <= 1'b0;
    end else begin
      state_q <= state_d;
      busy_q <= imem_valid;
      if (spec_take) begin
        addr_q <= {spec_addr[31:2], 2'b00};
      end else if (refill) begin
        addr_q <= addr_q + 32'd4;
      end
      if (state_q == st_clear) begin
        sweep_q <= sweep_q + 1'b1;                // wraps after the last index.
      end
      if (req.valid & req.fence) begin
        fence_q <= 1'b1;
      end else if (state_q == st_clear && sweep_last) begin
        fence_q <= 1'b0;
      end
      if (req.valid & req.spec) begin
        spec_q <= 1'b1;
      end else if (spec_take) begin
        spec_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (req.valid & req.spec) begin
      spec_addr_q <= req.addr;
    end
  end

  assign imem_valid = (state_q == st_active) & ~full & ~fence_pend & ~spec_pend;
  assign imem_addr = addr_q;

endmodule

// File: hdl/fetch_align.sv
`include "fetch_defines.svh"

module fetch_align (
  input logic clock,
  input logic reset,
  input mem_pkg::mem_req_t req,
  fetch_ram_if.reader ram,
  output mem_pkg::mem_resp_t resp,
  output logic [1:0] step
);

  import fetch_pkg::*;

  logic [31:0] addr_q;
  logic have_q;
  logic served_q;
  logic fence_q;
  logic [31:0] addr;
  logic [31:0] addr_next;
  logic have;
  logic served;
  logic blocked;
  logic byp1;
  logic byp2;
  logic hit1;
  logic hit2;
  fetch_entry_t ent1;
  fetch_entry_t ent2;
  logic [31:0] rdata;
  logic error;
  logic ready;
  logic comp;

  assign addr = req.valid ? req.addr : addr_q;
  assign addr_next = addr + 32'd4;
  assign have = req.valid | have_q;
  assign served = ~req.valid & served_q;          // step counted once.
  // a fence waits for the first refill after the sweep.
  assign blocked = req.valid ? req.fence : (fence_q & ~(ram.wen & ram.wdata.valid));

  assign ram.raddr1 = addr[`FETCH_INDEX_W+1:2];
  assign ram.raddr2 = addr_next[`FETCH_INDEX_W+1:2];

  // ***************************************************************************
  // tag compare with write bypass
  // ***************************************************************************

  assign byp1 = ram.wen & ram.wdata.valid & (ram.wdata.tag == addr[31:2]);
  assign byp2 = ram.wen & ram.wdata.valid & (ram.wdata.tag == addr_next[31:2]);
  assign ent1 = byp1 ? ram.wdata : ram.rdata1;
  assign ent2 = byp2 ? ram.wdata : ram.rdata2;
  assign hit1 = byp1 | (ram.rdata1.valid & (ram.rdata1.tag == addr[31:2]));
  assign hit2 = byp2 | (ram.rdata2.valid & (ram.rdata2.tag == addr_next[31:2]));

  always_comb begin
    rdata = ent1.data;
    error = ent1.error;
    ready = hit1;
    if (addr[1]) begin
      rdata = {16'h0000, ent1.data[31:16]};     // upper half first.
      if (rdata[1:0] == 2'b11) begin
        rdata[31:16] = ent2.data[15:0];
        error = ent2.error;
        ready = hit1 & hit2;
      end
    end
    comp = (rdata[1:0] != 2'b11);
    if (comp) begin
      rdata[31:16] = 16'h0000;
    end
  end

  assign resp.ready = have & ~blocked & ready;
  assign resp.error = error;
  assign resp.rdata = rdata;
  assign step = (resp.ready & ~served) ? (comp ? 2'd1 : 2'd2) : 2'd0;

  always_ff @(posedge clock) begin
    if (reset) begin
      have_q <= 1'b0;
      served_q <= 1'b0;
      fence_q <= 1'b0;
    end else begin
      have_q <= have;
      served_q <= served | resp.ready;
      fence_q <= blocked;
    end
  end

  always_ff @(posedge clock) begin
    if (req.valid) begin
      addr_q <= req.addr;
    end
  end

endmodule

// File: hdl/fetch_buffer.sv
module fetch_buffer (
  input logic clock,
  input logic reset,
  input logic req_valid,
  input logic req_fence,
  input logic req_spec,
  input logic [31:0] req_addr,
  output logic resp_ready,
  output logic resp_error,
  output logic [31:0] resp_rdata,
  output logic imem_valid,
  output logic [31:0] imem_addr,
  input logic imem_ready,
  input logic imem_error,
  input logic [31:0] imem_rdata
);

  import mem_pkg::*;

  mem_req_t req;
  mem_resp_t resp;
  logic refill;
  logic clear;
  logic full;
  logic [1:0] step;

  assign req = '{valid: req_valid, fence: req_fence, spec: req_spec, addr: req_addr};
  assign resp_ready = resp.ready;
  assign resp_error = resp.error;
  assign resp_rdata = resp.rdata;

  fetch_ram_if ram_bus ();

  fetch_ram ram0 (
    .clock (clock),
    .ram   (ram_bus.store)
  );

  fetch_occupancy occupancy0 (
    .clock  (clock),
    .reset  (reset),
    .refill (refill),
    .clear  (clear),
    .step   (step),
    .full   (full)
  );

  fetch_ctrl ctrl0 (
    .clock      (clock),
    .reset      (reset),
    .req        (req),
    .imem_ready (imem_ready),
    .imem_error (imem_error),
    .imem_rdata (imem_rdata),
    .full       (full),
    .imem_valid (imem_valid),
    .imem_addr  (imem_addr),
    .refill     (refill),
    .clear      (clear),
    .ram        (ram_bus.writer)
  );

  fetch_align align0 (
    .clock (clock),
    .reset (reset),
    .req   (req),
    .ram   (ram_bus.reader),
    .resp  (resp),
    .step  (step)
  );

endmodule

// File: tb/fetch_buffer_checker.sv
`include "fetch_defines.svh"

module fetch_buffer_checker (
  input logic clock,
  input logic reset,
  input logic imem_valid,
  input logic imem_ready,
  input logic resp_ready,
  input logic wen,
  input logic [`FETCH_INDEX_W+1:0] count,
  input fetch_pkg::fetch_state_t state
);

  import fetch_pkg::*;

  // quiet outputs right after reset.
  assert property (@(posedge clock) $fell(reset) |-> !imem_valid && !resp_ready)
    else $error("imem_valid or resp_ready high in the cycle after reset");

  // one fetch may land beyond the limit.
  assert property (@(posedge clock) disable iff (reset)
    int'(count) <= `FETCH_LIMIT + 2)
    else $error("occupancy above the limit");

  assert property (@(posedge clock) disable iff (reset)
    wen && !imem_ready |-> state == st_clear)
    else $error("entry write without a memory answer outside the sweep");

endmodule

bind fetch_buffer fetch_buffer_checker checker0 (
  .clock      (clock),
  .reset      (reset),
  .imem_valid (imem_valid),
  .imem_ready (imem_ready),
  .resp_ready (resp_ready),
  .wen        (ram_bus.wen),
  .count      (occupancy0.count_q),
  .state      (ctrl0.state_q)
);

// File: tb/fetch_buffer_tb.sv
`include "fetch_defines.svh"

module fetch_buffer_tb;

  localparam logic [31:0] comp_base = 32'h180;  // first word with compressed low half.
  localparam logic [31:0] err_addr = 32'h12c;

  typedef struct {
    string name;
    logic [31:0] addr;
    logic fence;
    logic spec;
    logic [31:0] exp_data;
    logic exp_error;
    int max_wait;
  } case_t;

  logic clock = 1'b0;
  logic reset;
  logic req_valid;
  logic req_fence;
  logic req_spec;
  logic [31:0] req_addr;
  logic resp_ready;
  logic resp_error;
  logic [31:0] resp_rdata;
  logic imem_valid;
  logic [31:0] imem_addr;
  logic imem_ready;
  logic imem_error;
  logic [31:0] imem_rdata;
  logic valid_seen;
  logic [15:0] salt [64];
  integer seed;
  case_t cases [$];
  int checks = 0;
  int mismatches = 0;
  int timeouts = 0;
  int early_answers = 0;

  fetch_buffer dut0 (
    .clock      (clock),
    .reset      (reset),
    .req_valid  (req_valid),
    .req_fence  (req_fence),
    .req_spec   (req_spec),
    .req_addr   (req_addr),
    .resp_ready (resp_ready),
    .resp_error (resp_error),
    .resp_rdata (resp_rdata),
    .imem_valid (imem_valid),
    .imem_addr  (imem_addr),
    .imem_ready (imem_ready),
    .imem_error (imem_error),
    .imem_rdata (imem_rdata)
  );

  always #5 clock = ~clock;

  // ***************************************************************************
  // memory rule
  // ***************************************************************************

  function automatic logic is_comp(input logic [29:0] w);
    return (w >= comp_base[31:2]) && ((w - comp_base[31:2]) % 3 == 0);
  endfunction

  // even words carry a compressed upper half.
  function automatic logic [31:0] mem_word(input logic [31:0] a);
    logic [29:0] w;
    logic [15:0] hi;
    logic [15:0] lo;
    w = a[31:2];
    hi = {salt[w[5:0]][15:2] ^ w[19:6] ^ {4'h0, w[29:20]}, w[0] ? 2'b11 : 2'b10};
    lo = {w[13:0], is_comp(w) ? 2'b01 : 2'b11};
    return {hi, lo};
  endfunction

  function automatic logic err_at(input logic [31:0] a);
    return a[31:2] == err_addr[31:2];
  endfunction

  function automatic logic hi_full(input logic [31:0] a);
    logic [31:0] word;
    word = mem_word(a);
    return a[1] && word[17:16] == 2'b11;
  endfunction

  function automatic logic [31:0] expect_data(input logic [31:0] a);
    logic [31:0] word;
    logic [31:0] next;
    word = mem_word(a);
    next = mem_word(a + 32'd4);
    if (!a[1]) begin
      return (word[1:0] == 2'b11) ? word : {16'h0000, word[15:0]};
    end
    return (word[17:16] == 2'b11) ? {next[15:0], word[31:16]} : {16'h0000, word[31:16]};
  endfunction

  function automatic logic expect_error(input logic [31:0] a);
    return hi_full(a) ? err_at(a + 32'd4) : err_at(a);
  endfunction

  task automatic add_case(input string name, input logic [31:0] addr,
                          input logic fence, input logic spec);
    case_t c;
    c.name = name;
    c.addr = addr;
    c.fence = fence;
    c.spec = spec;
    c.exp_data = expect_data(addr);
    c.exp_error = expect_error(addr);
    c.max_wait = 20 + (fence ? 2 * `FETCH_DEPTH : 0);      // sweep adds depth cycles.
    cases.push_back(c);
  endtask

  // ***************************************************************************
  // memory model, one cycle behind imem_valid
  // ***************************************************************************

  always @(posedge clock) begin
    valid_seen <= reset ? 1'b0 : imem_valid;
  end

  always @(negedge clock) begin
    imem_ready = valid_seen;
    imem_rdata = valid_seen ? mem_word(imem_addr) : 32'h0;
    imem_error = valid_seen & err_at(imem_addr);
  end

  task automatic apply_case(input case_t c);
    int waited;
    @(negedge clock);
    req_valid = 1'b1;
    req_addr = c.addr;
    req_fence = c.fence;
    req_spec = c.spec;
    #2;
    waited = 0;
    while (!resp_ready && waited < c.max_wait) begin
      @(negedge clock);
      req_valid = 1'b0;
      req_fence = 1'b0;
      req_spec = 1'b0;
      #2;
      waited++;
    end
    if (!resp_ready) begin
      timeouts++;
      $display("no response for case %s within %0d cycles", c.name, c.max_wait);
    end else begin
      checks++;
      assert (resp_rdata === c.exp_data) else begin
        mismatches++;
        $display("mismatch %s data: expected %h, actual %h", c.name, c.exp_data, resp_rdata);
      end
      assert (resp_error === c.exp_error) else begin
        mismatches++;
        $display("mismatch %s error: expected %b, actual %b", c.name, c.exp_error, resp_error);
      end
      // a fence answer needs the full sweep and a refill first.
      if (c.fence) begin
        checks++;
        assert (waited > `FETCH_DEPTH) else begin
          early_answers++;
          $display("case %s answered after %0d cycles, before the sweep and refill",
                   c.name, waited);
        end
      end
    end
  endtask

  task automatic wait_valid(input logic level, input int max_cycles, input string what);
    int waited;
    waited = 0;
    @(negedge clock);
    req_valid = 1'b0;
    req_fence = 1'b0;
    req_spec = 1'b0;
    #2;
    while (imem_valid !== level && waited < max_cycles) begin
      @(negedge clock);
      #2;
      waited++;
    end
    checks++;
    assert (imem_valid === level) else begin
      timeouts++;
      $display("imem_valid did not %s within %0d cycles", what, max_cycles);
    end
  endtask

  initial begin
    @(negedge reset);
    repeat (200 * cases.size()) @(posedge clock);
    $display("watchdog expired after %0d cycles", 200 * cases.size());
    $display("TESTS FAILED");
    $finish;
  end

  initial begin
    seed = 32'h43d2;
    for (int i = 0; i < 64; i++) begin
      salt[i] = 16'($random(seed));
    end
    reset = 1'b1;
    req_valid = 1'b0;
    req_fence = 1'b0;
    req_spec = 1'b0;
    req_addr = 32'h0;
    imem_ready = 1'b0;
    imem_error = 1'b0;
    imem_rdata = 32'h0;
    add_case("initial word 0", 32'h000, 1'b0, 1'b0);
    add_case("initial word 1", 32'h004, 1'b0, 1'b0);
    add_case("spec redirect", 32'h100, 1'b0, 1'b1);
    for (int a = 32'h104; a <= 32'h130; a += 4) begin
      add_case($sformatf("sequential %h", a), a, 1'b0, 1'b0);
    end
    add_case("spec compressed", 32'h180, 1'b0, 1'b1);
    add_case("upper compressed", 32'h182, 1'b0, 1'b0);
    add_case("full after halves", 32'h184, 1'b0, 1'b0);
    add_case("full word", 32'h188, 1'b0, 1'b0);
    add_case("lower compressed", 32'h18c, 1'b0, 1'b0);
    add_case("split full", 32'h18e, 1'b0, 1'b0);
    add_case("upper after split", 32'h192, 1'b0, 1'b0);
    add_case("full after upper", 32'h194, 1'b0, 1'b0);
    add_case("fence refetch", 32'h194, 1'b1, 1'b1);
    add_case("after fence comp", 32'h198, 1'b0, 1'b0);
    add_case("after fence upper", 32'h19a, 1'b0, 1'b0);
    add_case("after fence full", 32'h19c, 1'b0, 1'b0);
    repeat (16) @(negedge clock);
    reset = 1'b0;

    // prefetch must stop at the occupancy limit.
    wait_valid(1'b1, 20, "rise after reset");
    wait_valid(1'b0, 40, "fall at the occupancy limit");
    repeat (10) begin
      @(negedge clock);
      #2;
      checks++;
      assert (imem_valid === 1'b0) else begin
        timeouts++;
        $display("imem_valid rose with nothing consumed");
      end
    end

    for (int i = 0; i < cases.size(); i++) begin
      apply_case(cases[i]);
      if (i == 1) begin
        wait_valid(1'b1, 20, "rise after consumption");
      end
    end
    @(negedge clock);
    req_valid = 1'b0;

    $display("checks %0d, mismatches %0d, timeouts %0d, early answers %0d",
             checks, mismatches, timeouts, early_answers);
    if (mismatches + timeouts + early_answers == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: fetch_buffer.f
+incdir+hdl
hdl/mem_pkg.sv
hdl/fetch_pkg.sv
hdl/fetch_ram_if.sv
hdl/fetch_ram.sv
hdl/fetch_occupancy.sv
hdl/fetch_ctrl.sv
hdl/fetch_align.sv
hdl/fetch_buffer.sv
tb/fetch_buffer_checker.sv
tb/fetch_buffer_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the fetch buffer testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Ihdl -f fetch_buffer.f \
  --top-module fetch_buffer_tb -o fetch_buffer_sim

./obj_dir/fetch_buffer_sim | tee sim.log

if grep -q "TESTS FAILED" sim.log; then
  exit 1
fi
exit 0
